// File: rtl/dma_reg_pkg.sv
package dma_reg_pkg;

    // register data and transfer ids share one width
    localparam int unsigned RegDataWidth = 64;
    // byte address of the register bus
    localparam int unsigned RegAddrWidth = 6;

    // register map, one 64 bit word per slot
    localparam logic [RegAddrWidth-1:0] RegSrcAddr  = 6'h00;
    localparam logic [RegAddrWidth-1:0] RegDstAddr  = 6'h08;
    localparam logic [RegAddrWidth-1:0] RegNumBytes = 6'h10;
    localparam logic [RegAddrWidth-1:0] RegConf     = 6'h18;
    localparam logic [RegAddrWidth-1:0] RegStatus   = 6'h20;
    localparam logic [RegAddrWidth-1:0] RegNextId   = 6'h28;
    localparam logic [RegAddrWidth-1:0] RegDone     = 6'h30;

    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    typedef struct packed {
        logic                    valid;
        reg_op_e                 op;
        logic [RegAddrWidth-1:0] addr;
        logic [RegDataWidth-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                    ready;
        logic [RegDataWidth-1:0] rdata;
    } reg_rsp_t;

    // conf register bits, serialize sits in bit 0
    typedef struct packed {
        logic decouple;
        logic deburst;
        logic serialize;
    } conf_t;

    typedef struct packed {
        logic [RegDataWidth-1:0] src;
        logic [RegDataWidth-1:0] dst;
        logic [RegDataWidth-1:0] num_bytes;
        conf_t                   conf;
    } reg_cfg_t;

endpackage

// File: rtl/dma_burst_pkg.sv
package dma_burst_pkg;

    // address width on the memory side
    localparam int unsigned AddrWidth = 64;
    // bytes moved per beat
    localparam int unsigned BeatBytes = 8;
    // shift turning a byte count into a beat count
    localparam int unsigned BeatShift = $clog2(BeatBytes);
    // bursts that may wait behind the active one
    localparam int unsigned QueueDepth = 2;

    typedef struct packed {
        logic [AddrWidth-1:0] src;
        logic [AddrWidth-1:0] dst;
        logic [AddrWidth-1:0] num_bytes;
        dma_reg_pkg::conf_t   conf;
    } burst_req_t;

    // one address pair strobed per beat
    typedef struct packed {
        logic [AddrWidth-1:0] src;
        logic [AddrWidth-1:0] dst;
    } beat_t;

    typedef enum logic {
        ENG_IDLE = 1'b0,
        ENG_BUSY = 1'b1
    } engine_state_e;

endpackage

// File: rtl/dma_reg_file.sv
`timescale 1ns/100ps

module dma_reg_file (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  dma_reg_pkg::reg_req_t                reg_req_i,
    output dma_reg_pkg::reg_cfg_t                cfg_o,
    output logic                                 next_id_rd_o,
    input  logic                                 status_i,
    input  logic [dma_reg_pkg::RegDataWidth-1:0] next_id_i,
    input  logic [dma_reg_pkg::RegDataWidth-1:0] done_id_i,
    output logic [dma_reg_pkg::RegDataWidth-1:0] rdata_o
);

    import dma_reg_pkg::*;

    reg_cfg_t cfg_q;
    logic     wr_en;
    logic     wr_mapped;

    // valid is already qualified by the bus handshake upstream
    assign wr_en = reg_req_i.valid && (reg_req_i.op == REG_WRITE);

    // only the four configuration slots take writes
    assign wr_mapped = reg_req_i.addr inside {RegSrcAddr, RegDstAddr, RegNumBytes, RegConf};

    // decoded from op and addr alone, so the front end can derive ready from it
    assign next_id_rd_o = (reg_req_i.op == REG_READ) && (reg_req_i.addr == RegNextId);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (reg_req_i.addr)
                RegSrcAddr: begin
                    cfg_q.src <= reg_req_i.wdata;
                end
                RegDstAddr: begin
                    cfg_q.dst <= reg_req_i.wdata;
                end
                RegNumBytes: begin
                    cfg_q.num_bytes <= reg_req_i.wdata;
                end
                RegConf: begin
                    // upper bits of the word are dropped
                    cfg_q.conf <= conf_t'(reg_req_i.wdata[$bits(conf_t)-1:0]);
                end
                default: begin
                    // read-only and unmapped slots ignore writes
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

    // read mux, combinational from the current state
    always_comb begin
        case (reg_req_i.addr)
            RegSrcAddr: begin
                rdata_o = cfg_q.src;
            end
            RegDstAddr: begin
                rdata_o = cfg_q.dst;
            end
            RegNumBytes: begin
                rdata_o = cfg_q.num_bytes;
            end
            RegConf: begin
                rdata_o = RegDataWidth'(cfg_q.conf);
            end
            RegStatus: begin
                rdata_o = RegDataWidth'(status_i);
            end
            RegNextId: begin
                rdata_o = next_id_i;
            end
            RegDone: begin
                rdata_o = done_id_i;
            end
            default: begin
                // unmapped slots read as zero
                rdata_o = '0;
            end
        endcase
    end

    // stored configuration survives writes aimed at status, next_id, done or holes
    a_ro_write_ignored: assert property (@(posedge clk_i) disable iff (reset_i)
        (wr_en && !wr_mapped) |=> $stable(cfg_q));

endmodule

// File: rtl/dma_transfer_id_gen.sv
`timescale 1ns/100ps

module dma_transfer_id_gen (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 issue_i,
    input  logic                                 retire_i,
    output logic [dma_reg_pkg::RegDataWidth-1:0] next_o,
    output logic [dma_reg_pkg::RegDataWidth-1:0] completed_o
);

    import dma_reg_pkg::*;

    logic [RegDataWidth-1:0] issued_q;
    logic [RegDataWidth-1:0] retired_q;

    // issue and retire can land in the same cycle, each counter runs on its own
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issued_q  <= '0;
            retired_q <= '0;
        end else begin
            if (issue_i) begin
                issued_q <= issued_q + RegDataWidth'(1);
            end
            if (retire_i) begin
                retired_q <= retired_q + RegDataWidth'(1);
            end
        end
    end

    // ids start at 1, zero stays free to mean no launch
    assign next_o      = issued_q + RegDataWidth'(1);
    assign completed_o = retired_q;

    // the engine cannot finish a transfer the front end never issued
    a_retire_le_issue: assert property (@(posedge clk_i) disable iff (reset_i)
        retired_q <= issued_q);

endmodule

// File: rtl/dma_frontend.sv
`timescale 1ns/100ps

module dma_frontend (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  dma_reg_pkg::reg_req_t     reg_req_i,
    output dma_reg_pkg::reg_rsp_t     reg_rsp_o,
    output dma_burst_pkg::burst_req_t burst_req_o,
    output logic                      burst_valid_o,
    input  logic                      burst_ready_i,
    input  logic                      engine_idle_i,
    input  logic                      trans_complete_i
);

    import dma_reg_pkg::*;

    reg_req_t                req_gated;
    reg_cfg_t                cfg;
    logic                    next_id_rd;
    logic                    issue;
    logic [RegDataWidth-1:0] next_id;
    logic [RegDataWidth-1:0] done_id;
    logic [RegDataWidth-1:0] next_id_rdata;
    logic [RegDataWidth-1:0] rdata;

    dma_reg_file i_reg_file (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .reg_req_i    (req_gated),
        .cfg_o        (cfg),
        .next_id_rd_o (next_id_rd),
        .status_i     (~engine_idle_i),
        .next_id_i    (next_id_rdata),
        .done_id_i    (done_id),
        .rdata_o      (rdata)
    );

    // a next_id read only launches with a nonzero byte count
    assign burst_valid_o = reg_req_i.valid && next_id_rd && (cfg.num_bytes != '0);

    // bus stalls on a launch until the engine has room, other accesses finish at once
    always_comb begin
        reg_rsp_o.ready = burst_valid_o ? burst_ready_i : 1'b1;
        reg_rsp_o.rdata = rdata;
    end

    // reg file only sees accesses that complete this cycle
    always_comb begin
        req_gated       = reg_req_i;
        req_gated.valid = reg_req_i.valid && reg_rsp_o.ready;
    end

    // empty config answers 0 and launches nothing
    assign next_id_rdata = (cfg.num_bytes != '0) ? next_id : '0;

    // one id per accepted burst
    assign issue = burst_valid_o && burst_ready_i;

    dma_transfer_id_gen i_id_gen (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue),
        .retire_i    (trans_complete_i),
        .next_o      (next_id),
        .completed_o (done_id)
    );

    // stored registers map straight onto the burst request
    always_comb begin
        burst_req_o           = '0;
        burst_req_o.src       = cfg.src;
        burst_req_o.dst       = cfg.dst;
        burst_req_o.num_bytes = cfg.num_bytes;
        burst_req_o.conf      = cfg.conf;
    end

    // engine never sees an empty burst
    a_valid_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        burst_valid_o |-> (burst_req_o.num_bytes != '0));

endmodule

// File: rtl/dma_burst_engine.sv
`timescale 1ns/100ps

module dma_burst_engine #(
    parameter int unsigned Depth = dma_burst_pkg::QueueDepth
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  dma_burst_pkg::burst_req_t burst_req_i,
    input  logic                      burst_valid_i,
    output logic                      burst_ready_o,
    output logic                      idle_o,
    output logic                      trans_complete_o,
    output dma_burst_pkg::beat_t      beat_o,
    output logic                      beat_valid_o
);

    import dma_burst_pkg::*;

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    // circular queue of waiting bursts
    burst_req_t          queue_q [Depth];
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [CntWidth-1:0] count_q;

    // active burst
    engine_state_e        state_q;
    logic [AddrWidth-1:0] beats_left_q;
    logic [AddrWidth-1:0] src_q;
    logic [AddrWidth-1:0] dst_q;

    logic       push;
    logic       last_beat;
    logic       load;
    logic       pop;
    logic       enq;
    burst_req_t load_req;

    assign burst_ready_o = count_q < CntWidth'(Depth);
    assign push          = burst_valid_i && burst_ready_o;
    assign last_beat     = (state_q == ENG_BUSY) && (beats_left_q <= AddrWidth'(1));

    // next active burst is picked when idle or on the current last beat
    always_comb begin
        load     = 1'b0;
        load_req = queue_q[rd_ptr_q];
        if ((state_q == ENG_IDLE) || last_beat) begin
            if (count_q != '0) begin
                load = 1'b1;
            end else if (push) begin
                // empty queue, the new burst goes straight to the active slot
                load     = 1'b1;
                load_req = burst_req_i;
            end
        end
    end

    assign pop = load && (count_q != '0);
    assign enq = push && !(load && (count_q == '0));

    // queue storage
    always_ff @(posedge clk_i) begin
        if (enq) begin
            queue_q[wr_ptr_q] <= burst_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
            end
            count_q <= count_q + CntWidth'(enq) - CntWidth'(pop);
        end
    end

    // fsm and beat counter
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= ENG_IDLE;
            beats_left_q <= '0;
        end else if (load) begin
            state_q      <= ENG_BUSY;
            beats_left_q <= load_req.num_bytes >> BeatShift;
        end else if (state_q == ENG_BUSY) begin
            beats_left_q <= beats_left_q - AddrWidth'(1);
            if (last_beat) begin
                state_q <= ENG_IDLE;
            end
        end
    end

    // running addresses, one beat further each busy cycle
    always_ff @(posedge clk_i) begin
        if (load) begin
            src_q <= load_req.src;
            dst_q <= load_req.dst;
        end else if (state_q == ENG_BUSY) begin
            src_q <= src_q + AddrWidth'(BeatBytes);
            dst_q <= dst_q + AddrWidth'(BeatBytes);
        end
    end

    assign beat_valid_o     = (state_q == ENG_BUSY);
    assign beat_o.src       = src_q;
    assign beat_o.dst       = dst_q;
    assign trans_complete_o = last_beat;
    assign idle_o           = (state_q == ENG_IDLE) && (count_q == '0);

    a_no_beat_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == ENG_IDLE) |-> !beat_valid_o);

    // a full queue must hold off the front end
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        (count_q == CntWidth'(Depth)) |-> !enq);

endmodule

// File: rtl/dma_subsystem_top.sv
`timescale 1ns/100ps

module dma_subsystem_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dma_reg_pkg::reg_req_t reg_req_i,
    output dma_reg_pkg::reg_rsp_t reg_rsp_o,
    output dma_burst_pkg::beat_t  beat_o,
    output logic                  beat_valid_o
);

    import dma_burst_pkg::*;

    // front end to engine
    burst_req_t burst_req;
    logic       burst_valid;
    logic       burst_ready;
    logic       engine_idle;
    logic       trans_complete;

    dma_frontend i_frontend (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .reg_req_i        (reg_req_i),
        .reg_rsp_o        (reg_rsp_o),
        .burst_req_o      (burst_req),
        .burst_valid_o    (burst_valid),
        .burst_ready_i    (burst_ready),
        .engine_idle_i    (engine_idle),
        .trans_complete_i (trans_complete)
    );

    dma_burst_engine #(
        .Depth (QueueDepth)
    ) i_burst_engine (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .burst_req_i      (burst_req),
        .burst_valid_i    (burst_valid),
        .burst_ready_o    (burst_ready),
        .idle_o           (engine_idle),
        .trans_complete_o (trans_complete),
        .beat_o           (beat_o),
        .beat_valid_o     (beat_valid_o)
    );

endmodule

// File: bench/dma_tb_model.svh
`ifndef DMA_TB_MODEL_SVH
`define DMA_TB_MODEL_SVH

// one expected beat where last marks the final beat of its transfer
typedef struct packed {
    logic  last;
    beat_t beat;
} exp_beat_t;

// register state as the host sees it
reg_cfg_t                m_cfg = '0;
// transfers issued so far, and transfers whose last beat has gone by
logic [RegDataWidth-1:0] m_issued = '0;
logic [RegDataWidth-1:0] m_done = '0;
// a last beat seen this cycle retires at the next edge
logic                    done_pending = 1'b0;
logic                    beat_this_cycle = 1'b0;
// expected beats in launch order
exp_beat_t               exp_beats[$];

// value a read of addr should return right now
function automatic logic [RegDataWidth-1:0] model_read(input logic [RegAddrWidth-1:0] addr);
    case (addr)
        RegSrcAddr:  return m_cfg.src;
        RegDstAddr:  return m_cfg.dst;
        RegNumBytes: return m_cfg.num_bytes;
        RegConf:     return 64'(m_cfg.conf);
        // busy while beats are pending or one is on the port this cycle
        RegStatus:   return 64'((exp_beats.size() != 0) || beat_this_cycle);
        RegNextId:   return (m_cfg.num_bytes != '0) ? m_issued + 64'd1 : '0;
        RegDone:     return m_done;
        default:     return '0;
    endcase
endfunction

// effect of a completed access on the model
function automatic void model_apply(input reg_op_e op, input logic [RegAddrWidth-1:0] addr,
                                    input logic [RegDataWidth-1:0] wdata);
    exp_beat_t       item;
    logic [63:0]     n_beats;
    if (op == REG_WRITE) begin
        case (addr)
            RegSrcAddr:  m_cfg.src = wdata;
            RegDstAddr:  m_cfg.dst = wdata;
            RegNumBytes: m_cfg.num_bytes = wdata;
            // only the three conf bits are kept
            RegConf:     m_cfg.conf = conf_t'(wdata[2:0]);
            default:     ;
        endcase
    end else if ((addr == RegNextId) && (m_cfg.num_bytes != '0)) begin
        m_issued = m_issued + 64'd1;
        n_beats = m_cfg.num_bytes / 64'(BeatBytes);
        // beats walk both addresses up by one beat size
        for (logic [63:0] i = 64'd0; i < n_beats; i++) begin
            item.beat.src = m_cfg.src + i * 64'(BeatBytes);
            item.beat.dst = m_cfg.dst + i * 64'(BeatBytes);
            item.last = (i == n_beats - 64'd1);
            exp_beats.push_back(item);
        end
    end
endfunction

`endif

// File: bench/dma_tb.sv
`timescale 1ns/100ps

module dma_tb;

    import dma_reg_pkg::*;
    import dma_burst_pkg::*;

    localparam int unsigned ClkPeriod = 4;
    localparam int unsigned ResetCycles = 8;
    localparam logic [31:0] Seed = 32'hcd9a8c8e;
    localparam int unsigned NumPrograms = 40;
    localparam int unsigned MaxBeats = 8;
    // register accesses per random program of about one cycle each
    localparam int unsigned AccessesPerProgram = 14;
    localparam int unsigned MarginCycles = 400;
    localparam int unsigned TimeoutCycles =
        ResetCycles + NumPrograms * (MaxBeats + AccessesPerProgram) + MarginCycles;

    logic        clk = 1'b0;
    logic        reset;
    reg_req_t    reg_req;
    reg_rsp_t    reg_rsp;
    beat_t       beat;
    logic        beat_valid;
    int unsigned stall_cycles = 0;

    `include "dma_tb_model.svh"

    always #(ClkPeriod / 2) clk = ~clk;

    dma_subsystem_top dut_i (
        .clk_i        (clk),
        .reset_i      (reset),
        .reg_req_i    (reg_req),
        .reg_rsp_o    (reg_rsp),
        .beat_o       (beat),
        .beat_valid_o (beat_valid)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual));
    endtask

    // one bus access that starts and ends on a falling edge
    task automatic reg_access(input string name, input reg_op_e op,
                              input logic [RegAddrWidth-1:0] addr,
                              input logic [RegDataWidth-1:0] wdata);
        logic [RegDataWidth-1:0] expected;
        logic                    accepted;
        reg_req.valid = 1'b1;
        reg_req.op = op;
        reg_req.addr = addr;
        reg_req.wdata = wdata;
        accepted = 1'b0;
        while (!accepted) begin
            // sample well clear of both edges
            #1;
            if (reg_rsp.ready) begin
                expected = model_read(addr);
                if (op == REG_READ) begin
                    check_value(name, expected, reg_rsp.rdata);
                end
                model_apply(op, addr, wdata);
                accepted = 1'b1;
            end else begin
                stall_cycles++;
            end
            @(negedge clk);
        end
        reg_req.valid = 1'b0;
    endtask

    task automatic reg_write(input logic [RegAddrWidth-1:0] addr, input logic [63:0] data);
        reg_access("write", REG_WRITE, addr, data);
    endtask

    task automatic reg_read(input string name, input logic [RegAddrWidth-1:0] addr);
        reg_access(name, REG_READ, addr, '0);
    endtask

    // program random registers, poke a read-only slot, then launch
    task automatic run_program();
        logic [RegAddrWidth-1:0] ro_addr;
        reg_write(RegSrcAddr, {$urandom, $urandom} & ~64'h7);
        reg_write(RegDstAddr, {$urandom, $urandom} & ~64'h7);
        reg_write(RegNumBytes, 64'($urandom_range(MaxBeats, 0)) * 64'(BeatBytes));
        reg_write(RegConf, {$urandom, $urandom});
        reg_read("readback_src", RegSrcAddr);
        reg_read("readback_dst", RegDstAddr);
        reg_read("readback_num_bytes", RegNumBytes);
        reg_read("readback_conf", RegConf);
        case ($urandom_range(3, 0))
            0: ro_addr = RegStatus;
            1: ro_addr = RegNextId;
            2: ro_addr = RegDone;
            default: ro_addr = 6'h38;
        endcase
        reg_write(ro_addr, {$urandom, $urandom});
        reg_read("ro_write_done", RegDone);
        reg_read("ro_write_src", RegSrcAddr);
        reg_read("next_id", RegNextId);
        reg_read("status_running", RegStatus);
    endtask

    // short gaps between 8 beat bursts overrun the queue
    task automatic fill_queue();
        stall_cycles = 0;
        reg_write(RegNumBytes, 64'(MaxBeats * BeatBytes));
        for (int unsigned i = 0; i < 5; i++) begin
            reg_write(RegSrcAddr, 64'h1000 * 64'(i + 1));
            reg_read("back_to_back_id", RegNextId);
        end
        assert (stall_cycles != 0) else
            fail_run("the register bus never stalled although the burst queue was full");
        reg_read("status_outstanding", RegStatus);
    endtask

    task automatic drain_and_check();
        while (exp_beats.size() != 0) begin
            @(negedge clk);
        end
        // let the last completion reach the done counter
        repeat (2) @(negedge clk);
        reg_read("drained_status", RegStatus);
        reg_read("drained_done", RegDone);
    endtask

    // beat monitor samples registered outputs at the falling edge where they are steady
    always @(negedge clk) begin : beat_monitor
        exp_beat_t head;
        m_done = m_done + 64'(done_pending);
        done_pending = 1'b0;
        beat_this_cycle = (beat_valid === 1'b1);
        if (beat_valid === 1'b1) begin
            assert (exp_beats.size() != 0) else
                fail_run("a beat appeared on the memory port with no beat outstanding");
            head = exp_beats.pop_front();
            check_value("beat_src", head.beat.src, beat.src);
            check_value("beat_dst", head.beat.dst, beat.dst);
            done_pending = head.last;
        end
    end

    initial begin : watchdog
        #(TimeoutCycles * ClkPeriod);
        fail_run("timeout: the run did not finish within the expected time");
    end

    initial begin
        void'($urandom(Seed));
        reg_req = '0;
        reset = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        reset = 1'b0;
        // everything reads zero after reset, and an empty launch returns 0
        reg_read("reset_src", RegSrcAddr);
        reg_read("reset_num_bytes", RegNumBytes);
        reg_read("reset_status", RegStatus);
        reg_read("reset_done", RegDone);
        reg_read("empty_next_id", RegNextId);
        for (int unsigned p = 0; p < NumPrograms; p++) begin
            run_program();
        end
        fill_queue();
        drain_and_check();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
rtl/dma_reg_pkg.sv
rtl/dma_burst_pkg.sv
rtl/dma_reg_file.sv
rtl/dma_transfer_id_gen.sv
rtl/dma_frontend.sv
rtl/dma_burst_engine.sv
rtl/dma_subsystem_top.sv
bench/dma_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dma testbench with verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module dma_tb -f project.f

# simulation output goes to the screen and to sim.log
./obj_dir/Vdma_tb | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

echo "simulation passed"
